// File: flist.f
logic/rv32i_pkg.sv
logic/lsu_pkg.sv
logic/lane_select.sv
logic/load_extract.sv
logic/mem_access.sv
logic/perf_counters.sv
logic/lsu_top.sv
tb/lsu_checker.sv
tb/lsu_tb.sv

// File: logic/lane_select.sv
`timescale 1ns/1ps

module lane_select
import rv32i_pkg::*, lsu_pkg::*;
(
    input  rv32i_addr  addr,
    input  funct3_t    funct3,
    input  rv32i_word  store_data,
    output byte_mask_t mbe,
    output rv32i_word  wdata,
    output logic       misaligned
);

    logic [1:0]    offset;      // byte offset inside the word
    logic [4:0]    shamt;       // offset in bits
    store_funct3_t size;        // loads share the size encoding in the low bits

    assign offset = addr[1:0];
    assign shamt  = {offset, 3'b000};
    assign size   = store_funct3_t'({1'b0, funct3[1:0]});

    always_comb begin
        mbe        = '0;
        wdata      = '0;
        misaligned = 1'b0;

        case (size)
            sb: begin
                mbe   = byte_mask_t'(4'b0001 << offset);
                wdata = {24'b0, store_data[7:0]} << shamt;
            end
            sh: begin
                if (offset[0]) begin
                    misaligned = 1'b1;      // half-word crosses a lane pair
                end else begin
                    mbe   = byte_mask_t'(4'b0011 << offset);
                    wdata = {16'b0, store_data[15:0]} << shamt;
                end
            end
            sw: begin
                if (offset != 2'b00) begin
                    misaligned = 1'b1;
                end else begin
                    mbe   = 4'b1111;
                    wdata = store_data;
                end
            end
            default: begin
                // size 11 has no RV32I access, rejected the same way
                misaligned = 1'b1;
            end
        endcase
    end

endmodule : lane_select

// File: logic/load_extract.sv
`timescale 1ns/1ps

module load_extract
import rv32i_pkg::*, lsu_pkg::*;
(
    input  byte_mask_t mbe,
    input  funct3_t    funct3,
    input  rv32i_word  rdata,
    output rv32i_word  value
);

    logic [7:0]  byte_lane;     // addressed byte
    logic [15:0] half_lane;     // addressed half-word

    // one-hot mask picks the byte
    always_comb begin
        byte_lane = rdata[7:0];
        case (mbe)
            4'b0010: byte_lane = rdata[15:8];
            4'b0100: byte_lane = rdata[23:16];
            4'b1000: byte_lane = rdata[31:24];
            default: ;
        endcase
    end

    assign half_lane = mbe[2] ? rdata[31:16] : rdata[15:0];  // 1100 is the upper half

    always_comb begin
        case (load_funct3_t'(funct3))
            lb:      value = {{24{byte_lane[7]}}, byte_lane};
            lbu:     value = {24'b0, byte_lane};
            lh:      value = {{16{half_lane[15]}}, half_lane};
            lhu:     value = {16'b0, half_lane};
            default: value = rdata;     // lw
        endcase
    end

endmodule : load_extract

// File: logic/lsu_pkg.sv
package lsu_pkg;

    // types that belong to the load/store unit itself

    typedef logic [3:0] byte_mask_t;    // one enable per byte lane, bit 0 is the low byte

    // access sequencer states
    typedef enum logic [1:0] {
        idle,       // waiting for a strobe
        access,     // request on the memory bus, waiting for resp
        finish      // done pulse, result valid
    } access_state_t;

    // width of the load and store counters unless the top level overrides it
    localparam int COUNTER_WIDTH_DEFAULT = 32;

endpackage : lsu_pkg

// File: logic/lsu_top.sv
`timescale 1ns/1ps

module lsu_top
import rv32i_pkg::*, lsu_pkg::*;
#(
    parameter int counter_width = COUNTER_WIDTH_DEFAULT
)
(
    input  logic                     clk,
    input  logic                     rst_n,

    // pipeline side
    input  logic                     req_read,
    input  logic                     req_write,
    input  rv32i_addr                req_addr,
    input  funct3_t                  req_funct3,
    input  rv32i_word                req_store_data,
    output logic                     busy,
    output logic                     done,
    output logic                     misaligned,
    output rv32i_word                load_data,
    output logic [counter_width-1:0] load_count,
    output logic [counter_width-1:0] store_count,
    output logic                     load_overflow,
    output logic                     store_overflow,

    // data memory side
    output logic                     data_read,
    output logic                     data_write,
    output rv32i_addr                data_mem_address,
    output byte_mask_t               data_mbe,
    output rv32i_word                data_mem_wdata,
    input  rv32i_word                data_mem_rdata,
    input  logic                     data_mem_resp
);

    logic load_done;    // successful load finished
    logic store_done;

    mem_access i_mem_access (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_read         (req_read),
        .req_write        (req_write),
        .req_addr         (req_addr),
        .req_funct3       (req_funct3),
        .req_store_data   (req_store_data),
        .data_mem_rdata   (data_mem_rdata),
        .data_mem_resp    (data_mem_resp),
        .busy             (busy),
        .done             (done),
        .misaligned       (misaligned),
        .load_data        (load_data),
        .load_done        (load_done),
        .store_done       (store_done),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_mem_address (data_mem_address),
        .data_mbe         (data_mbe),
        .data_mem_wdata   (data_mem_wdata)
    );

    perf_counters #(
        .counter_width (counter_width)
    ) i_perf_counters (
        .clk            (clk),
        .rst_n          (rst_n),
        .load_done      (load_done),
        .store_done     (store_done),
        .load_count     (load_count),
        .store_count    (store_count),
        .load_overflow  (load_overflow),
        .store_overflow (store_overflow)
    );

endmodule : lsu_top

// File: logic/mem_access.sv
`timescale 1ns/1ps

module mem_access
import rv32i_pkg::*, lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       req_read,
    input  logic       req_write,
    input  rv32i_addr  req_addr,
    input  funct3_t    req_funct3,
    input  rv32i_word  req_store_data,

    input  rv32i_word  data_mem_rdata,
    input  logic       data_mem_resp,

    output logic       busy,
    output logic       done,
    output logic       misaligned,
    output rv32i_word  load_data,
    output logic       load_done,
    output logic       store_done,

    output logic       data_read,
    output logic       data_write,
    output rv32i_addr  data_mem_address,
    output byte_mask_t data_mbe,
    output rv32i_word  data_mem_wdata
);

    access_state_t state;

    logic       is_load_q;      // kind of the access in flight
    logic       misaligned_q;
    rv32i_addr  addr_q;         // word aligned
    funct3_t    funct3_q;
    byte_mask_t mbe_q;
    rv32i_word  wdata_q;
    rv32i_word  load_data_q;

    byte_mask_t lane_mbe;
    rv32i_word  lane_wdata;
    logic       lane_misaligned;
    rv32i_word  extract_value;
    logic       accept;

    // lanes are worked out from the live request and captured with it
    lane_select i_lane_select (
        .addr       (req_addr),
        .funct3     (req_funct3),
        .store_data (req_store_data),
        .mbe        (lane_mbe),
        .wdata      (lane_wdata),
        .misaligned (lane_misaligned)
    );

    load_extract i_load_extract (
        .mbe    (mbe_q),
        .funct3 (funct3_q),
        .rdata  (data_mem_rdata),
        .value  (extract_value)
    );

    assign accept = (state == idle) && (req_read || req_write);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= idle;
            is_load_q    <= 1'b0;
            misaligned_q <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (accept) begin
                        is_load_q    <= req_read;           // read wins if both strobe
                        misaligned_q <= lane_misaligned;
                        state        <= lane_misaligned ? finish : access;
                    end
                end
                access: begin
                    if (data_mem_resp) begin
                        state <= finish;
                    end
                end
                finish:  state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q   <= {req_addr[31:2], 2'b00};
            funct3_q <= req_funct3;
            mbe_q    <= lane_mbe;
            wdata_q  <= lane_wdata;
        end
        if ((state == access) && data_mem_resp && is_load_q) begin
            load_data_q <= extract_value;   // rdata only valid in the resp cycle
        end
    end

    assign busy       = (state != idle);
    assign done       = (state == finish);
    assign misaligned = done && misaligned_q;
    assign load_data  = load_data_q;
    assign load_done  = done && !misaligned_q && is_load_q;
    assign store_done = done && !misaligned_q && !is_load_q;

    // request held until resp, address and lanes come from the registers
    assign data_read        = (state == access) && is_load_q;
    assign data_write       = (state == access) && !is_load_q;
    assign data_mem_address = addr_q;
    assign data_mbe         = mbe_q;
    assign data_mem_wdata   = wdata_q;

endmodule : mem_access

// File: logic/perf_counters.sv
`timescale 1ns/1ps

module perf_counters
import lsu_pkg::*;
#(
    parameter int counter_width = COUNTER_WIDTH_DEFAULT
)
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load_done,
    input  logic                     store_done,
    output logic [counter_width-1:0] load_count,
    output logic [counter_width-1:0] store_count,
    output logic                     load_overflow,
    output logic                     store_overflow
);

    logic [1:0]               inc;              // index 0 loads, index 1 stores
    logic [counter_width-1:0] count_q [2];
    logic [1:0]               overflow_q;

    assign inc = {store_done, load_done};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q[0] <= '0;
            count_q[1] <= '0;
            overflow_q <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (inc[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;    // wraps at the top
                    if (count_q[i] == '1) begin
                        overflow_q[i] <= 1'b1;          // sticky until reset
                    end
                end
            end
        end
    end

    assign load_count     = count_q[0];
    assign store_count    = count_q[1];
    assign load_overflow  = overflow_q[0];
    assign store_overflow = overflow_q[1];

endmodule : perf_counters

// File: logic/rv32i_pkg.sv
package rv32i_pkg;

    // instruction-level types shared by the pipeline and the load/store unit

    typedef logic [31:0] rv32i_word;    // data word as seen by registers and memory
    typedef logic [31:0] rv32i_addr;    // byte address

    // raw funct3 field from the instruction
    // carries either a load_funct3_t or a store_funct3_t
    typedef logic [2:0] funct3_t;

    // load variants, low two bits give the access size
    // bit 2 selects zero extension
    typedef enum logic [2:0] {
        lb  = 3'b000,   // byte, sign extended
        lh  = 3'b001,   // half-word, sign extended
        lw  = 3'b010,   // word
        lbu = 3'b100,   // byte, zero extended
        lhu = 3'b101    // half-word, zero extended
    } load_funct3_t;

    // store variants, same size encoding as the loads
    typedef enum logic [2:0] {
        sb = 3'b000,    // byte
        sh = 3'b001,    // half-word
        sw = 3'b010     // word
    } store_funct3_t;

endpackage : rv32i_pkg

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lsu_tb -f flist.f -o lsu_sim \
    && ./obj_dir/lsu_sim | tee /dev/stderr | grep -q "^Result: PASSED$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb/lsu_checker.sv
`timescale 1ns/1ps

module lsu_checker
import rv32i_pkg::*, lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       data_read,
    input  logic       data_write,
    input  rv32i_addr  data_mem_address,
    input  byte_mask_t data_mbe,
    input  rv32i_word  data_mem_wdata,
    input  logic       data_mem_resp,
    input  logic       done
);

    logic request;

    assign request = data_read || data_write;

    read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_read && data_write))
        else $error("data_read and data_write are high together");

    request_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        request |-> (data_mbe != 4'b0000) && (data_mem_address[1:0] == 2'b00))
        else $error("request with an empty mask or an unaligned address");

    // held until the memory answers
    request_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (request && !data_mem_resp) |=>
            $stable({data_read, data_write, data_mem_address, data_mbe, data_mem_wdata}))
        else $error("request changed before data_mem_resp");

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done high for two cycles in a row");

endmodule : lsu_checker

// File: tb/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb
import rv32i_pkg::*, lsu_pkg::*;
();

    localparam int CW         = 4;      // small so that both counters wrap
    localparam int MAX_CYCLES = 4000;   // 106 accesses of at most 8 cycles, about 4x margin

    logic                clk = 1'b0;
    logic                rst_n;
    logic                req_read;
    logic                req_write;
    rv32i_addr           req_addr;
    funct3_t             req_funct3;
    rv32i_word           req_store_data;
    logic                busy;
    logic                done;
    logic                misaligned;
    rv32i_word           load_data;
    logic [CW-1:0]       load_count;
    logic [CW-1:0]       store_count;
    logic                load_overflow;
    logic                store_overflow;
    logic                data_read;
    logic                data_write;
    rv32i_addr           data_mem_address;
    byte_mask_t          data_mbe;
    rv32i_word           data_mem_wdata;
    rv32i_word           data_mem_rdata;
    logic                data_mem_resp;

    logic [7:0]  mem [64];      // memory model
    logic [7:0]  shadow [64];   // what the memory should hold
    logic [15:0] lfsr = 16'd5474;
    logic [1:0]  next_delay;    // resp delay of the next access
    logic [1:0]  wait_left;
    logic        pending;
    byte_mask_t  seen_mbe;
    int          mem_requests;

    // expectations of the access in flight
    logic        exp_is_load;
    logic        exp_mis;
    byte_mask_t  exp_mbe;
    rv32i_word   exp_data;
    int          start_requests;
    logic        in_flight;

    int          n_loads;
    int          n_stores;
    logic        counts_due;
    int          errors = 0;
    int          test_start = 0;
    int          tests_run = 0;
    int          cycle_count = 0;

    always #10 clk = ~clk;

    lsu_top #(.counter_width(CW)) i_dut (.*);

    bind lsu_top lsu_checker i_lsu_checker (
        .clk              (clk),
        .rst_n            (rst_n),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_mem_address (data_mem_address),
        .data_mbe         (data_mbe),
        .data_mem_wdata   (data_mem_wdata),
        .data_mem_resp    (data_mem_resp),
        .done             (done)
    );

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic rv32i_word model_word(input logic [3:0] w);
        return {mem[{w, 2'd3}], mem[{w, 2'd2}], mem[{w, 2'd1}], mem[{w, 2'd0}]};
    endfunction

    function automatic rv32i_word shadow_word(input logic [3:0] w);
        return {shadow[{w, 2'd3}], shadow[{w, 2'd2}], shadow[{w, 2'd1}], shadow[{w, 2'd0}]};
    endfunction

    function automatic logic is_misaligned(input rv32i_addr addr, input funct3_t f3);
        case (f3[1:0])
            2'd0:    return 1'b0;
            2'd1:    return addr[0];
            default: return addr[1:0] != 2'b00;
        endcase
    endfunction

    // one enable for every byte the access covers, starting at the byte offset
    function automatic byte_mask_t expected_mask(input rv32i_addr addr, input funct3_t f3);
        byte_mask_t m;
        int         first;
        int         nbytes;
        m      = '0;
        first  = int'(addr[1:0]);
        nbytes = 1 << f3[1:0];
        for (int lane = 0; lane < 4; lane++) begin
            m[lane] = (lane >= first) && (lane < first + nbytes);
        end
        return m;
    endfunction

    // little endian, bytes taken straight from the model at the byte address
    function automatic rv32i_word expected_load(input rv32i_addr addr, input funct3_t f3);
        logic [5:0] a;
        logic [7:0] b0;
        logic [7:0] b1;
        a  = addr[5:0];
        b0 = mem[a];
        b1 = mem[a + 6'd1];
        case (load_funct3_t'(f3))
            lb:      return {{24{b0[7]}}, b0};
            lbu:     return {24'h0, b0};
            lh:      return {{16{b1[7]}}, b1, b0};
            lhu:     return {16'h0, b1, b0};
            default: return {mem[a + 6'd3], mem[a + 6'd2], b1, b0};
        endcase
    endfunction

    task automatic check_word(input string name, input rv32i_word got, input rv32i_word expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_mask(input string name, input byte_mask_t got,
                              input byte_mask_t expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_logic(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [CW-1:0] got,
                               input logic [CW-1:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, expected);
            errors++;
        end
    endtask

    // memory model, request held until the resp cycle
    initial begin
        data_mem_resp  = 1'b0;
        data_mem_rdata = '0;
        pending        = 1'b0;
        wait_left      = 2'd0;
        mem_requests   = 0;
        forever begin
            @(posedge clk);
            #2;
            data_mem_resp = 1'b0;
            if (data_read || data_write) begin
                if (!pending) begin
                    pending   = 1'b1;
                    wait_left = next_delay;
                    seen_mbe  = data_mbe;
                    mem_requests++;
                end
                if (wait_left == 2'd0) begin
                    data_mem_resp = 1'b1;
                    pending       = 1'b0;
                    if (data_write) begin
                        for (int i = 0; i < 4; i++) begin
                            if (data_mbe[i]) begin
                                mem[{data_mem_address[5:2], 2'(i)}] = data_mem_wdata[8*i +: 8];
                            end
                        end
                    end else begin
                        data_mem_rdata = model_word(data_mem_address[5:2]);
                    end
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    // compare process, results at done and counters one cycle later
    always @(negedge clk) begin
        if (!rst_n) begin
            n_loads    = 0;
            n_stores   = 0;
            counts_due = 1'b0;
        end else begin
            if (counts_due) begin
                check_count("load_count", load_count, CW'(n_loads));
                check_count("store_count", store_count, CW'(n_stores));
                check_logic("load_overflow", load_overflow, n_loads >= (1 << CW));
                check_logic("store_overflow", store_overflow, n_stores >= (1 << CW));
                counts_due = 1'b0;
            end
            if (in_flight) begin
                check_logic("busy", busy, 1'b1);
            end
            if (done) begin
                check_logic("misaligned", misaligned, exp_mis);
                check_logic("memory request", mem_requests != start_requests, !exp_mis);
                if (!exp_mis) begin
                    check_mask("data_mbe", seen_mbe, exp_mbe);
                    if (exp_is_load) begin
                        check_word("load_data", load_data, exp_data);
                        n_loads++;
                    end else begin
                        n_stores++;
                        for (int w = 0; w < 16; w++) begin
                            check_word($sformatf("mem word %0d", w), model_word(4'(w)),
                                       shadow_word(4'(w)));
                        end
                    end
                end
                counts_due = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped finishing accesses", cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    // one access from strobe to the idle cycle after done
    task automatic run_access(input logic is_load, input rv32i_addr addr, input funct3_t f3,
                              input rv32i_word data);
        int nbytes;
        exp_is_load    = is_load;
        exp_mis        = is_misaligned(addr, f3);
        exp_mbe        = expected_mask(addr, f3);
        exp_data       = is_load ? expected_load(addr, f3) : data;
        start_requests = mem_requests;
        next_delay     = 2'(rand_bits(2));
        if (!is_load && !exp_mis) begin
            nbytes = 1 << f3[1:0];
            for (int i = 0; i < nbytes; i++) begin
                shadow[addr[5:0] + 6'(i)] = data[8*i +: 8];
            end
        end
        req_read       = is_load;
        req_write      = !is_load;
        req_addr       = addr;
        req_funct3     = f3;
        req_store_data = data;
        @(posedge clk);
        #2;
        req_read  = 1'b0;
        req_write = 1'b0;
        in_flight = 1'b1;
        while (!done) begin
            @(posedge clk);
            #2;
        end
        in_flight = 1'b0;
        @(posedge clk);     // counters step here
        #2;
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        #2;
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - test_start);
        test_start = errors;
    endtask

    initial begin
        logic [2:0] sel;
        funct3_t    f3;
        req_read       = 1'b0;
        req_write      = 1'b0;
        req_addr       = '0;
        req_funct3     = '0;
        req_store_data = '0;
        in_flight      = 1'b0;
        next_delay     = 2'd0;
        apply_reset();

        // every lane of word 2, read back after each store
        run_access(1'b0, 32'd8, sw, rand_bits(32));
        run_access(1'b1, 32'd8, lw, 32'h0);
        for (int off = 0; off < 4; off++) begin
            run_access(1'b0, rv32i_addr'(8 + off), sb, rand_bits(32));
            run_access(1'b1, 32'd8, lw, 32'h0);
        end
        for (int off = 0; off < 4; off += 2) begin
            run_access(1'b0, rv32i_addr'(8 + off), sh, rand_bits(32));
            run_access(1'b1, 32'd8, lw, 32'h0);
        end
        end_test("store lanes");

        // fill with sign bits set in alternating bytes
        for (int w = 0; w < 16; w++) begin
            run_access(1'b0, rv32i_addr'(4 * w), sw,
                       rand_bits(32) | (w[0] ? 32'h0080_0080 : 32'h8000_8000));
        end
        for (int w = 4; w < 6; w++) begin
            for (int off = 0; off < 4; off++) begin
                run_access(1'b1, rv32i_addr'(4 * w + off), lb, 32'h0);
                run_access(1'b1, rv32i_addr'(4 * w + off), lbu, 32'h0);
            end
            for (int off = 0; off < 4; off += 2) begin
                run_access(1'b1, rv32i_addr'(4 * w + off), lh, 32'h0);
                run_access(1'b1, rv32i_addr'(4 * w + off), lhu, 32'h0);
            end
        end
        end_test("sign extension");

        run_access(1'b1, 32'd13, lh, 32'h0);
        run_access(1'b1, 32'd15, lh, 32'h0);
        run_access(1'b1, 32'd17, lhu, 32'h0);
        run_access(1'b1, 32'd21, lw, 32'h0);
        run_access(1'b1, 32'd22, lw, 32'h0);
        run_access(1'b1, 32'd23, lw, 32'h0);
        run_access(1'b0, 32'd25, sh, rand_bits(32));
        run_access(1'b0, 32'd27, sh, rand_bits(32));
        run_access(1'b0, 32'd30, sw, rand_bits(32));
        end_test("misaligned");

        for (int k = 0; k < 24; k++) begin
            if (rand_bits(1) == 32'd1) begin
                sel = 3'(rand_bits(3));
                case (sel)
                    3'd0:    f3 = lb;
                    3'd1:    f3 = lh;
                    3'd2:    f3 = lbu;
                    3'd3:    f3 = lhu;
                    default: f3 = lw;
                endcase
                run_access(1'b1, rand_bits(6), f3, 32'h0);
            end else begin
                sel = 3'(rand_bits(2));
                case (sel)
                    3'd0:    f3 = sb;
                    3'd1:    f3 = sh;
                    default: f3 = sw;
                endcase
                run_access(1'b0, rand_bits(6), f3, rand_bits(32));
            end
        end
        end_test("random mix");

        // 17 loads wrap the 4-bit load counter once
        apply_reset();
        for (int k = 0; k < 17; k++) begin
            run_access(1'b1, rand_bits(4) << 2, lw, 32'h0);
            if (k % 6 == 5) begin
                run_access(1'b0, rand_bits(4) << 2, sw, rand_bits(32));
            end
        end
        end_test("counter wrap");

        $display("%0d tests, %0d errors, %0d cycles", tests_run, errors, cycle_count);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : lsu_tb
